// File: sim.f
+incdir+include
rtl/busPkg.sv
rtl/coherencePkg.sv
rtl/lineStore.sv
rtl/memPort.sv
rtl/coherenceController.sv
rtl/snoopCache.sv
test/snoopCacheTb.sv

// File: run.sh
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and scans the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module snoopCacheTb -f sim.f -o simv

# the log decides the result, so a fatal exit code must not stop the script here
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0

// File: test/cacheCases.txt
// kind (0 read, 1 write, 2 snoop), addr, wdata or snoop msg, exp rdata, exp msg, exp reads
// msg 0 none 1 read miss 2 write miss 3 invalidate; then write addr and word, ffffffff = none
0 0010 00000000 00100010 1 1 ffffffff 00000000
0 0010 00000000 00100010 0 0 ffffffff 00000000
1 0020 cafe0001 00000000 2 1 ffffffff 00000000
0 0020 00000000 cafe0001 0 0 ffffffff 00000000
0 0030 00000000 00300030 1 1 00000020 cafe0001
1 0030 12345678 00000000 3 0 ffffffff 00000000
0 0040 00000000 00400040 1 1 00000030 12345678
0 0020 00000000 cafe0001 1 1 ffffffff 00000000
1 0020 0badf00d 00000000 3 0 ffffffff 00000000
2 0020 00000001 00000000 0 0 00000020 0badf00d
0 0020 00000000 0badf00d 0 0 ffffffff 00000000
2 0099 00000002 00000000 0 0 ffffffff 00000000
0 0020 00000000 0badf00d 0 0 ffffffff 00000000
2 0020 00000003 00000000 0 0 ffffffff 00000000
0 0020 00000000 0badf00d 1 1 ffffffff 00000000
1 0050 5a5a5a5a 00000000 2 1 ffffffff 00000000
2 0050 00000002 00000000 0 0 00000050 5a5a5a5a
0 0050 00000000 5a5a5a5a 1 1 ffffffff 00000000
2 0050 00000002 00000000 0 0 ffffffff 00000000
0 0050 00000000 5a5a5a5a 1 1 ffffffff 00000000
2 0050 00000001 00000000 0 0 ffffffff 00000000
0 0050 00000000 5a5a5a5a 0 0 ffffffff 00000000
1 0060 11112222 00000000 2 1 ffffffff 00000000
1 0060 33334444 00000000 0 0 ffffffff 00000000
0 0070 00000000 00700070 1 1 00000060 33334444

// File: test/snoopCacheTb.sv
// Testbench for the single-line MSI snooping cache.
// Replays test/cacheCases.txt through the CPU and snoop ports against a memory model.
`include "cache_settings.svh"

module snoopCacheTb
    import coherencePkg::*;
    import busPkg::*;
();

    localparam int resetCycles = 10;
    localparam int caseCount   = 25;
    localparam int columnCount = 8;
    localparam int memDepth    = 1 << `ADDR_WIDTH;
    localparam int cycleLimit  = caseCount * (2 * `MEM_TIMEOUT + 10) + resetCycles;
    localparam logic [31:0] noWrite = 32'hffffffff;

    logic                   clk       = 1'b0;
    logic                   reset     = 1'b1;
    logic                   cpuReq    = 1'b0;
    accessOp_e              cpuOp     = opRead;
    logic [`ADDR_WIDTH-1:0] cpuAddr   = '0;
    logic [`WORD_WIDTH-1:0] cpuWdata  = '0;
    logic                   memAck    = 1'b0;
    logic [`WORD_WIDTH-1:0] memRdata  = '0;
    busMsg_e                busInMsg  = msgNone;
    logic [`ADDR_WIDTH-1:0] busInAddr = '0;
    logic                   cpuAck;
    logic [`WORD_WIDTH-1:0] cpuRdata;
    logic                   memReq;
    accessOp_e              memOp;
    logic [`ADDR_WIDTH-1:0] memAddr;
    logic [`WORD_WIDTH-1:0] memWdata;
    busMsg_e                busOutMsg;
    logic [`ADDR_WIDTH-1:0] busOutAddr;

    logic [31:0]            caseWords [0:caseCount*columnCount-1];
    logic [`WORD_WIDTH-1:0] memory [0:memDepth-1];

    // activity seen by the memory model and the bus monitor
    int                     readCount     = 0;
    int                     writeCount    = 0;
    logic [`ADDR_WIDTH-1:0] lastWriteAddr = '0;
    logic [`WORD_WIDTH-1:0] lastWriteData = '0;
    int                     msgCount      = 0;
    busMsg_e                lastMsg       = msgNone;
    logic [`ADDR_WIDTH-1:0] lastMsgAddr   = '0;
    int                     cycleCount    = 0;

    snoopCache DUT (
        .clk        (clk),
        .reset      (reset),
        .cpuReq     (cpuReq),
        .cpuOp      (cpuOp),
        .cpuAddr    (cpuAddr),
        .cpuWdata   (cpuWdata),
        .cpuAck     (cpuAck),
        .cpuRdata   (cpuRdata),
        .memAck     (memAck),
        .memRdata   (memRdata),
        .memReq     (memReq),
        .memOp      (memOp),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .busInMsg   (busInMsg),
        .busInAddr  (busInAddr),
        .busOutMsg  (busOutMsg),
        .busOutAddr (busOutAddr)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("simulation timed out after %0d cycles", cycleCount);
            $display("CHECKS FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // memory model, each word starts as its own address in both halves
    initial begin
        int   delayLeft;
        logic busy;
        busy = 1'b0;
        delayLeft = 0;
        void'($urandom(32'h2da4));
        for (int a = 0; a < memDepth; a++) begin
            memory[a] = {2{`ADDR_WIDTH'(a)}};
        end
        forever begin
            @(posedge clk);
            if (memAck) begin
                if (!memReq) begin
                    memAck <= 1'b0;
                end
            end else if (busy) begin
                if (delayLeft == 0) begin
                    busy = 1'b0;
                    memAck <= 1'b1;
                    if (memOp == opWrite) begin
                        memory[memAddr] = memWdata;
                        writeCount    <= writeCount + 1;
                        lastWriteAddr <= memAddr;
                        lastWriteData <= memWdata;
                    end else begin
                        memRdata  <= memory[memAddr];
                        readCount <= readCount + 1;
                    end
                end else begin
                    delayLeft = delayLeft - 1;
                end
            end else if (memReq && !reset) begin
                busy = 1'b1;
                delayLeft = int'($urandom_range(`MEM_TIMEOUT, 1)) - 1;
            end
        end
    end

    // broadcast monitor
    always @(posedge clk) begin
        if (!reset && busOutMsg != msgNone) begin
            msgCount    <= msgCount + 1;
            lastMsg     <= busOutMsg;
            lastMsgAddr <= busOutAddr;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // full four-phase CPU access, returns the word seen while cpuAck is high
    task automatic cpuAccess(input accessOp_e op, input logic [`ADDR_WIDTH-1:0] addr,
                             input logic [`WORD_WIDTH-1:0] wdata,
                             output logic [`WORD_WIDTH-1:0] rdata);
        cpuReq   <= 1'b1;
        cpuOp    <= op;
        cpuAddr  <= addr;
        cpuWdata <= wdata;
        @(posedge clk);
        while (!cpuAck) @(posedge clk);
        rdata = cpuRdata;
        cpuReq <= 1'b0;
        @(posedge clk);
        while (cpuAck) @(posedge clk);
    endtask

    task automatic sendSnoop(input busMsg_e msg, input logic [`ADDR_WIDTH-1:0] addr,
                             input logic expectWriteBack, input int baseWrites);
        busInMsg  <= msg;
        busInAddr <= addr;
        @(posedge clk);
        busInMsg <= msgNone;
        if (expectWriteBack) begin
            @(posedge clk);
            while (writeCount == baseWrites || memAck || memReq) @(posedge clk);
        end else begin
            repeat (2) @(posedge clk);
            checkValue("memReq after snoop", 32'(memReq), 32'h0);
        end
    endtask

    initial begin
        logic [31:0]            kind;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [31:0]            expRdata;
        logic [31:0]            expMsg;
        logic [31:0]            expReads;
        logic [31:0]            expWrAddr;
        logic [31:0]            expWrData;
        logic [`WORD_WIDTH-1:0] gotRdata;
        int                     baseReads;
        int                     baseWrites;
        int                     baseMsgs;

        $readmemh("test/cacheCases.txt", caseWords);
        if ($isunknown(caseWords[caseCount*columnCount-1])) begin
            $display("could not read every case from test/cacheCases.txt");
            $display("CHECKS FAILED");
            $fatal(1, "missing stimulus");
        end

        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < caseCount; i++) begin
            kind      = caseWords[i*columnCount];
            addr      = caseWords[i*columnCount+1];
            data      = caseWords[i*columnCount+2];
            expRdata  = caseWords[i*columnCount+3];
            expMsg    = caseWords[i*columnCount+4];
            expReads  = caseWords[i*columnCount+5];
            expWrAddr = caseWords[i*columnCount+6];
            expWrData = caseWords[i*columnCount+7];
            baseReads  = readCount;
            baseWrites = writeCount;
            baseMsgs   = msgCount;

            if (kind == 2) begin
                sendSnoop(busMsg_e'(data[1:0]), addr[`ADDR_WIDTH-1:0],
                          expWrAddr != noWrite, baseWrites);
            end else begin
                cpuAccess((kind == 1) ? opWrite : opRead, addr[`ADDR_WIDTH-1:0],
                          data, gotRdata);
                if (kind == 0) begin
                    checkValue($sformatf("cpuRdata case %0d", i), gotRdata, expRdata);
                end
            end

            checkValue($sformatf("broadcast count case %0d", i), msgCount - baseMsgs,
                       (expMsg != 0) ? 32'h1 : 32'h0);
            if (expMsg != 0) begin
                checkValue($sformatf("busOutMsg case %0d", i), 32'(lastMsg), expMsg);
                checkValue($sformatf("busOutAddr case %0d", i), 32'(lastMsgAddr), addr);
            end
            checkValue($sformatf("memory read count case %0d", i), readCount - baseReads,
                       expReads);
            checkValue($sformatf("memory write count case %0d", i), writeCount - baseWrites,
                       (expWrAddr != noWrite) ? 32'h1 : 32'h0);
            if (expWrAddr != noWrite) begin
                checkValue($sformatf("memAddr write case %0d", i), 32'(lastWriteAddr),
                           expWrAddr);
                checkValue($sformatf("memWdata write case %0d", i), lastWriteData,
                           expWrData);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: rtl/snoopCache.sv
// Top level of the single-line MSI snooping cache.
// Connects line storage, the coherence FSM and the memory master.
`include "cache_settings.svh"

module snoopCache
    import coherencePkg::*;
    import busPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // CPU port
    input  logic                   cpuReq,
    input  accessOp_e              cpuOp,
    input  logic [`ADDR_WIDTH-1:0] cpuAddr,
    input  logic [`WORD_WIDTH-1:0] cpuWdata,
    output logic                   cpuAck,
    output logic [`WORD_WIDTH-1:0] cpuRdata,

    // memory port
    input  logic                   memAck,
    input  logic [`WORD_WIDTH-1:0] memRdata,
    output logic                   memReq,
    output accessOp_e              memOp,
    output logic [`ADDR_WIDTH-1:0] memAddr,
    output logic [`WORD_WIDTH-1:0] memWdata,

    // coherence bus
    input  busMsg_e                busInMsg,
    input  logic [`ADDR_WIDTH-1:0] busInAddr,
    output busMsg_e                busOutMsg,
    output logic [`ADDR_WIDTH-1:0] busOutAddr
);

    // line store to controller
    lineState_e             lineState;
    logic [`ADDR_WIDTH-1:0] lineTag;
    logic [`WORD_WIDTH-1:0] lineData;
    logic                   cpuHit;
    logic                   snoopHit;

    // controller to line store
    logic                   lineUpdate;
    lineState_e             lineNewState;
    logic [`ADDR_WIDTH-1:0] lineNewAddr;
    logic [`WORD_WIDTH-1:0] lineNewData;

    // controller to memory master
    logic                   memStart;
    accessOp_e              accessOp;
    logic [`ADDR_WIDTH-1:0] accessAddr;
    logic [`WORD_WIDTH-1:0] accessWdata;
    logic                   memDone;
    logic [`WORD_WIDTH-1:0] fillData;

    lineStore line (
        .clk       (clk),
        .reset     (reset),
        .update    (lineUpdate),
        .newState  (lineNewState),
        .newAddr   (lineNewAddr),
        .newData   (lineNewData),
        .cpuAddr   (cpuAddr),
        .snoopAddr (busInAddr),
        .state     (lineState),
        .tag       (lineTag),
        .data      (lineData),
        .cpuHit    (cpuHit),
        .snoopHit  (snoopHit)
    );

    coherenceController ctrl (
        .clk        (clk),
        .reset      (reset),
        .cpuReq     (cpuReq),
        .cpuOp      (cpuOp),
        .cpuAddr    (cpuAddr),
        .cpuWdata   (cpuWdata),
        .cpuAck     (cpuAck),
        .cpuRdata   (cpuRdata),
        .busInMsg   (busInMsg),
        .state      (lineState),
        .tag        (lineTag),
        .data       (lineData),
        .cpuHit     (cpuHit),
        .snoopHit   (snoopHit),
        .update     (lineUpdate),
        .newState   (lineNewState),
        .newAddr    (lineNewAddr),
        .newData    (lineNewData),
        .memDone    (memDone),
        .memRdata   (fillData),
        .memStart   (memStart),
        .memOp      (accessOp),
        .memAddr    (accessAddr),
        .memWdata   (accessWdata),
        .busOutMsg  (busOutMsg),
        .busOutAddr (busOutAddr)
    );

    memPort mem (
        .clk      (clk),
        .reset    (reset),
        .start    (memStart),
        .op       (accessOp),
        .addr     (accessAddr),
        .wdata    (accessWdata),
        .done     (memDone),
        .rdata    (fillData),
        .memAck   (memAck),
        .memRdata (memRdata),
        .memReq   (memReq),
        .memOp    (memOp),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

endmodule

// File: rtl/coherenceController.sv
// MSI coherence FSM for the single-line cache. Serves CPU hits and misses,
// runs write-backs and refills through the memory port, and reacts to snoops.
`include "cache_settings.svh"

module coherenceController
    import coherencePkg::*;
    import busPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // CPU port
    input  logic                   cpuReq,
    input  accessOp_e              cpuOp,
    input  logic [`ADDR_WIDTH-1:0] cpuAddr,
    input  logic [`WORD_WIDTH-1:0] cpuWdata,
    output logic                   cpuAck,
    output logic [`WORD_WIDTH-1:0] cpuRdata,

    // incoming snoop message, address is compared in the line store
    input  busMsg_e                busInMsg,

    // line store
    input  lineState_e             state,
    input  logic [`ADDR_WIDTH-1:0] tag,
    input  logic [`WORD_WIDTH-1:0] data,
    input  logic                   cpuHit,
    input  logic                   snoopHit,
    output logic                   update,
    output lineState_e             newState,
    output logic [`ADDR_WIDTH-1:0] newAddr,
    output logic [`WORD_WIDTH-1:0] newData,

    // memory port
    input  logic                   memDone,
    input  logic [`WORD_WIDTH-1:0] memRdata,
    output logic                   memStart,
    output accessOp_e              memOp,
    output logic [`ADDR_WIDTH-1:0] memAddr,
    output logic [`WORD_WIDTH-1:0] memWdata,

    // outgoing broadcast
    output busMsg_e                busOutMsg,
    output logic [`ADDR_WIDTH-1:0] busOutAddr
);

    ctrlState_e             ctrlState;
    ctrlState_e             ctrlNext;
    lineState_e             pendingState;
    lineState_e             pendingNext;
    busMsg_e                msgNext;
    logic                   loadRdata;
    logic [`WORD_WIDTH-1:0] rdataNext;

    always_comb begin
        ctrlNext    = ctrlState;
        pendingNext = pendingState;
        msgNext     = msgNone;
        loadRdata   = 1'b0;
        rdataNext   = data;
        memStart    = 1'b0;
        memOp       = opRead;
        memAddr     = cpuAddr;
        memWdata    = data;
        update      = 1'b0;
        newState    = state;
        newAddr     = tag;
        newData     = data;

        case (ctrlState)
            ctrlIdle: begin
                // snoops win over the CPU in the same cycle
                if (snoopHit && busInMsg != msgNone) begin
                    if (state == lineModified) begin
                        memStart    = 1'b1;
                        memOp       = opWrite;
                        memAddr     = tag;
                        pendingNext = (busInMsg == msgReadMiss) ? lineShared : lineInvalid;
                        ctrlNext    = ctrlSnoopWriteBack;
                    end else if (busInMsg != msgReadMiss) begin
                        update   = 1'b1;
                        newState = lineInvalid;
                    end
                end else if (cpuReq) begin
                    if (cpuHit) begin
                        ctrlNext = ctrlRespond;
                        if (cpuOp == opRead) begin
                            loadRdata = 1'b1;
                        end else begin
                            update   = 1'b1;
                            newState = lineModified;
                            newData  = cpuWdata;
                            // other sharers must drop their copies
                            if (state == lineShared) begin
                                msgNext = msgInvalidate;
                            end
                        end
                    end else begin
                        msgNext  = (cpuOp == opRead) ? msgReadMiss : msgWriteMiss;
                        memStart = 1'b1;
                        if (state == lineModified) begin
                            memOp    = opWrite;
                            memAddr  = tag;
                            ctrlNext = ctrlMissWriteBack;
                        end else begin
                            ctrlNext = ctrlFill;
                        end
                    end
                end
            end
            ctrlMissWriteBack: begin
                // old line is out, now fetch the new word
                if (memDone) begin
                    memStart = 1'b1;
                    ctrlNext = ctrlFill;
                end
            end
            ctrlFill: begin
                if (memDone) begin
                    update   = 1'b1;
                    newAddr  = cpuAddr;
                    ctrlNext = ctrlRespond;
                    if (cpuOp == opRead) begin
                        newState  = lineShared;
                        newData   = memRdata;
                        loadRdata = 1'b1;
                        rdataNext = memRdata;
                    end else begin
                        newState = lineModified;
                        newData  = cpuWdata;
                    end
                end
            end
            ctrlSnoopWriteBack: begin
                if (memDone) begin
                    update   = 1'b1;
                    newState = pendingState;
                    ctrlNext = ctrlIdle;
                end
            end
            ctrlRespond: begin
                if (cpuAck && !cpuReq) begin
                    ctrlNext = ctrlIdle;
                end
            end
            default: ctrlNext = ctrlIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlState <= ctrlIdle;
            cpuAck    <= 1'b0;
            busOutMsg <= msgNone;
        end else begin
            ctrlState <= ctrlNext;
            busOutMsg <= msgNext;
            // ack rises one cycle into respond and falls after cpuReq drops
            if (ctrlState == ctrlRespond) begin
                if (!cpuAck) begin
                    cpuAck <= 1'b1;
                end else if (!cpuReq) begin
                    cpuAck <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        pendingState <= pendingNext;
        if (loadRdata) begin
            cpuRdata <= rdataNext;
        end
        if (msgNext != msgNone) begin
            busOutAddr <= cpuAddr;
        end
    end

endmodule

// File: rtl/memPort.sv
// Four-phase memory master. Each start pulse runs one read or write,
// and done pulses once the memory has dropped its acknowledge.
`include "cache_settings.svh"

module memPort
    import busPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // request from the controller
    input  logic                   start,
    input  accessOp_e              op,
    input  logic [`ADDR_WIDTH-1:0] addr,
    input  logic [`WORD_WIDTH-1:0] wdata,
    output logic                   done,
    output logic [`WORD_WIDTH-1:0] rdata,

    // memory side
    input  logic                   memAck,
    input  logic [`WORD_WIDTH-1:0] memRdata,
    output logic                   memReq,
    output accessOp_e              memOp,
    output logic [`ADDR_WIDTH-1:0] memAddr,
    output logic [`WORD_WIDTH-1:0] memWdata
);

    typedef enum logic [1:0] {
        portIdle,
        portRequest,
        portRelease,
        portWaitAckLow
    } portState_e;

    portState_e portState;

    always_ff @(posedge clk) begin
        if (reset) begin
            portState <= portIdle;
            memReq    <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (portState)
                portIdle: begin
                    if (start) begin
                        memReq    <= 1'b1;
                        portState <= portRequest;
                    end
                end
                portRequest: begin
                    if (memAck) begin
                        portState <= portRelease;
                    end
                end
                portRelease: begin
                    memReq    <= 1'b0;
                    portState <= portWaitAckLow;
                end
                portWaitAckLow: begin
                    if (!memAck) begin
                        done      <= 1'b1;
                        portState <= portIdle;
                    end
                end
                default: portState <= portIdle;
            endcase
        end
    end

    // request fields stay put for the whole handshake
    always_ff @(posedge clk) begin
        if (portState == portIdle && start) begin
            memOp    <= op;
            memAddr  <= addr;
            memWdata <= wdata;
        end
        if (portState == portRequest && memAck) begin
            rdata <= memRdata;
        end
    end

endmodule

// File: rtl/lineStore.sv
// Storage for the single cache line: tag, data word and MSI state.
// Flags CPU and snoop address hits combinationally from the stored tag.
`include "cache_settings.svh"

module lineStore
    import coherencePkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // write port from the controller
    input  logic                   update,
    input  lineState_e             newState,
    input  logic [`ADDR_WIDTH-1:0] newAddr,
    input  logic [`WORD_WIDTH-1:0] newData,

    // addresses to compare against the tag
    input  logic [`ADDR_WIDTH-1:0] cpuAddr,
    input  logic [`ADDR_WIDTH-1:0] snoopAddr,

    output lineState_e             state,
    output logic [`ADDR_WIDTH-1:0] tag,
    output logic [`WORD_WIDTH-1:0] data,
    output logic                   cpuHit,
    output logic                   snoopHit
);

    logic lineValid;

    // line starts out invalid
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lineInvalid;
        end else if (update) begin
            state <= newState;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            tag  <= newAddr;
            data <= newData;
        end
    end

    assign lineValid = (state != lineInvalid);

    // hit tests
    assign cpuHit   = lineValid && (tag == cpuAddr);
    assign snoopHit = lineValid && (tag == snoopAddr);

endmodule

// File: rtl/coherencePkg.sv
// MSI line states and the controller sequence states.
// Imported by the line storage, the controller and the top level.
package coherencePkg;

    // MSI state of the single cache line
    typedef enum logic [1:0] {
        lineInvalid,
        lineShared,
        lineModified
    } lineState_e;

    // sequencing of hits, misses, write-backs and snoops
    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlSnoopWriteBack,
        ctrlMissWriteBack,
        ctrlFill,
        ctrlRespond
    } ctrlState_e;

endpackage

// File: rtl/busPkg.sv
// Access opcodes for the CPU and memory ports and the coherence bus messages.
// Imported by any block that drives or decodes these buses.
package busPkg;

    // CPU or memory access
    typedef enum logic {
        opRead,
        opWrite
    } accessOp_e;

    // one-cycle message on the snoop bus
    typedef enum logic [1:0] {
        msgNone,
        msgReadMiss,
        msgWriteMiss,
        msgInvalidate
    } busMsg_e;

endpackage

// File: include/cache_settings.svh
// Widths and memory timing shared by the cache RTL and its testbench.
// Include wherever address or word widths are needed.
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// word address and data word
`define ADDR_WIDTH 16
`define WORD_WIDTH 32

// longest memory acknowledge delay in cycles, sizes the testbench watchdog
`define MEM_TIMEOUT 4

`endif
